/* common/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// --------------------------------------------------
// opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_ANDI  6'h0C
`define OP_ORI   6'h0D
`define OP_XORI  6'h0E
`define OP_LW    6'h23
`define OP_SW    6'h2B
`define OP_HLT   6'h3F

// funct codes under OP_RTYPE
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_JR  6'h08
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_XOR 6'h26
`define FN_SLT 6'h2A

// --------------------------------------------------
// ALU operation codes
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR  4'd3
`define ALU_XOR 4'd4
`define ALU_SLT 4'd5
`define ALU_SLL 4'd6
`define ALU_SRL 4'd7

// next-PC sources
`define PCSEL_SEQ     2'd0
`define PCSEL_TARGET  2'd1
`define PCSEL_HANDLER 2'd2
`define PCSEL_RSVD    2'd3

// --------------------------------------------------
// memories, word addressed
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256
`define MEM_AW     8

`define HANDLER_ADDR 32'd200
`define LINK_REG     5'd31

`endif

/* common/cpu_pkg.sv */
package cpu_pkg;

	// --------------------------------------------------
	// basic vectors
	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;
	typedef logic [3:0]  aluOp_t;
	typedef logic [1:0]  pcSel_t;

	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [15:0] imm_t;
	typedef logic [25:0] jTarget_t;

	// --------------------------------------------------
	// instruction word split into every field it can carry
	typedef struct packed {
		opcode_t  opcode;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		shamt_t   shamt;
		funct_t   funct;
		imm_t     imm;
		jTarget_t target;
	} instrFields_t;

	// control outputs of the decoder
	typedef struct packed {
		logic   regDst;   // write rd instead of rt
		logic   aluSrc;   // operand 2 is the immediate
		logic   memToReg;
		logic   memWrite;
		logic   regWrite;
		aluOp_t aluOp;
		logic   zeroExt;  // andi, ori and xori take an unsigned immediate
		logic   shiftOp;  // rt and shamt feed the ALU
		logic   link;     // jal writes the return address to r31
		logic   halt;
	} ctrl_t;

endpackage

/* verilog/alu.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu import cpu_pkg::*; (
	input  word_t  a,
	input  word_t  b,
	input  aluOp_t op,
	output word_t  result,
	output logic   zero
);

	logic [4:0] shAmt;

	assign shAmt = b[4:0];

	always_comb begin
		case (op)
			`ALU_ADD: result = a + b;
			`ALU_SUB: result = a - b;
			`ALU_AND: result = a & b;
			`ALU_OR:  result = a | b;
			`ALU_XOR: result = a ^ b;
			`ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			`ALU_SLL: result = a << shAmt;
			`ALU_SRL: result = a >> shAmt; // logical, zero fill
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/1ps

module registerFile import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     we,
	input  regAddr_t readReg1,
	input  regAddr_t readReg2,
	input  regAddr_t writeReg,
	input  regAddr_t dbgAddr,
	input  word_t    writeData,
	output word_t    readData1,
	output word_t    readData2,
	output word_t    dbgData
);

	word_t regs [32];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && writeReg != 5'd0) begin
			regs[writeReg] <= writeData; // r0 is never written so it stays zero
		end
	end

	assign readData1 = regs[readReg1];
	assign readData2 = regs[readReg2];
	assign dbgData   = regs[dbgAddr];

endmodule

/* memory/instMem.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instMem import cpu_pkg::*; (
	input  logic  clk,
	input  logic  we,
	input  word_t waddr,
	input  word_t raddr,
	input  word_t wdata,
	output word_t rdata
);

	word_t mem [`IMEM_DEPTH];

	// program load port, used while the core sits in reset
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr[`MEM_AW-1:0]] <= wdata;
	end

	assign rdata = mem[raddr[`MEM_AW-1:0]];

endmodule

/* memory/dataMem.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module dataMem import cpu_pkg::*; (
	input  logic  clk,
	input  logic  we,
	input  word_t addr,
	input  word_t wdata,
	output word_t rdata
);

	word_t              mem [`DMEM_DEPTH];
	logic [`MEM_AW-1:0] wordIdx;

	assign wordIdx = addr[`MEM_AW-1:0]; // upper address bits are ignored

	always_ff @(posedge clk) begin
		if (we)
			mem[wordIdx] <= wdata;
	end

	assign rdata = mem[wordIdx];

endmodule

/* decode/controlUnit.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module controlUnit import cpu_pkg::*; (
	input  instrFields_t fields,
	output ctrl_t        ctrl
);

	always_comb begin
		ctrl = '0; // illegal encodings keep every enable low
		case (fields.opcode)
			// --------------------------------------------------
			`OP_RTYPE: begin
				ctrl.regDst   = 1'b1;
				ctrl.regWrite = 1'b1;
				case (fields.funct)
					`FN_ADD: ctrl.aluOp = `ALU_ADD;
					`FN_SUB: ctrl.aluOp = `ALU_SUB;
					`FN_AND: ctrl.aluOp = `ALU_AND;
					`FN_OR:  ctrl.aluOp = `ALU_OR;
					`FN_XOR: ctrl.aluOp = `ALU_XOR;
					`FN_SLT: ctrl.aluOp = `ALU_SLT;
					`FN_SLL: begin
						ctrl.aluOp   = `ALU_SLL;
						ctrl.aluSrc  = 1'b1;
						ctrl.shiftOp = 1'b1;
					end
					`FN_SRL: begin
						ctrl.aluOp   = `ALU_SRL;
						ctrl.aluSrc  = 1'b1;
						ctrl.shiftOp = 1'b1;
					end
					default: ctrl = '0; // jr writes nothing, unknown funct likewise
				endcase
			end
			// --------------------------------------------------
			`OP_ADDI: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = `ALU_ADD;
			end
			`OP_ANDI, `OP_ORI, `OP_XORI: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.zeroExt  = 1'b1;
				if (fields.opcode == `OP_ANDI)
					ctrl.aluOp = `ALU_AND;
				else if (fields.opcode == `OP_ORI)
					ctrl.aluOp = `ALU_OR;
				else
					ctrl.aluOp = `ALU_XOR;
			end
			`OP_LW: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = `ALU_ADD; // base plus offset
			end
			`OP_SW: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluOp    = `ALU_ADD;
			end
			`OP_BEQ, `OP_BNE: ctrl.aluOp = `ALU_SUB; // compare is in the branch controller
			`OP_J: ctrl = '0;
			`OP_JAL: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.link     = 1'b1;
				ctrl.aluOp    = `ALU_ADD;
			end
			`OP_HLT: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

/* decode/branchController.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module branchController import cpu_pkg::*; (
	input  instrFields_t fields,
	input  word_t        rsData,
	input  word_t        rtData,
	output pcSel_t       pcSel
);

	logic opEqual;

	assign opEqual = (rsData == rtData);

	always_comb begin
		pcSel = `PCSEL_SEQ;
		case (fields.opcode)
			`OP_RTYPE: begin
				case (fields.funct)
					`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLL, `FN_SRL:
						pcSel = `PCSEL_SEQ;
					`FN_JR:  pcSel = `PCSEL_TARGET;
					default: pcSel = `PCSEL_HANDLER; // unknown funct
				endcase
			end
			`OP_J, `OP_JAL: pcSel = `PCSEL_TARGET;
			`OP_BEQ: begin
				if (opEqual)
					pcSel = `PCSEL_TARGET;
			end
			`OP_BNE: begin
				if (!opEqual)
					pcSel = `PCSEL_TARGET;
			end
			`OP_ADDI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LW, `OP_SW, `OP_HLT:
				pcSel = `PCSEL_SEQ;
			default: pcSel = `PCSEL_HANDLER; // unknown opcode
		endcase
	end

endmodule

/* verilog/scCpu.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module scCpu import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     loadEn,
	input  word_t    loadAddr,
	input  word_t    loadData,
	input  regAddr_t dbgAddr,
	output word_t    pc,
	output word_t    cyclesConsumed,
	output logic     halted,
	output word_t    dbgData
);

	word_t        instr;
	instrFields_t fields;
	ctrl_t        ctrl;
	pcSel_t       pcSel;
	word_t        rsData, rtData;
	word_t        pcPlus1, branchTarget, nextPc;
	word_t        signImm, immExt;
	word_t        aluA, aluB, aluResult;
	word_t        memRdata, writeData;
	regAddr_t     writeReg;
	logic         commit;

	assign commit = rst && !halted; // an edge commits only while running

	// --------------------------------------------------
	// fetch and decode
	instMem instMem_i (
		.clk   (clk),
		.we    (loadEn),
		.waddr (loadAddr),
		.raddr (pc),
		.wdata (loadData),
		.rdata (instr)
	);

	assign fields.opcode = instr[31:26];
	assign fields.rs     = instr[25:21];
	assign fields.rt     = instr[20:16];
	assign fields.rd     = instr[15:11];
	assign fields.shamt  = instr[10:6];
	assign fields.funct  = instr[5:0];
	assign fields.imm    = instr[15:0];
	assign fields.target = instr[25:0];

	controlUnit controlUnit_i (.fields(fields), .ctrl(ctrl));

	branchController branchController_i (
		.fields (fields),
		.rsData (rsData),
		.rtData (rtData),
		.pcSel  (pcSel)
	);

	// --------------------------------------------------
	// next PC
	assign pcPlus1 = pc + 32'd1;
	assign signImm = {{16{fields.imm[15]}}, fields.imm};

	always_comb begin
		if (fields.opcode == `OP_J || fields.opcode == `OP_JAL)
			branchTarget = {6'd0, fields.target};
		else if (fields.opcode == `OP_RTYPE)
			branchTarget = rsData; // only jr reaches the target source here
		else
			branchTarget = pcPlus1 + signImm;
	end

	always_comb begin
		case (pcSel)
			`PCSEL_SEQ:                   nextPc = pcPlus1;
			`PCSEL_TARGET:                nextPc = branchTarget;
			`PCSEL_HANDLER, `PCSEL_RSVD:  nextPc = `HANDLER_ADDR;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc             <= '0;
			cyclesConsumed <= '0;
			halted         <= 1'b0;
		end else if (!halted) begin
			cyclesConsumed <= cyclesConsumed + 32'd1; // the hlt edge is counted too
			if (ctrl.halt)
				halted <= 1'b1; // pc stays on the hlt word
			else
				pc <= nextPc;
		end
	end

	// --------------------------------------------------
	// execute, memory and write-back
	registerFile registerFile_i (
		.clk       (clk),
		.rst       (rst),
		.we        (ctrl.regWrite && commit),
		.readReg1  (fields.rs),
		.readReg2  (fields.rt),
		.writeReg  (writeReg),
		.dbgAddr   (dbgAddr),
		.writeData (writeData),
		.readData1 (rsData),
		.readData2 (rtData),
		.dbgData   (dbgData)
	);

	always_comb begin
		if (ctrl.shiftOp)
			immExt = {27'd0, fields.shamt};
		else if (ctrl.link)
			immExt = 32'd1; // jal computes pc + 1 in the ALU
		else if (ctrl.zeroExt)
			immExt = {16'd0, fields.imm};
		else
			immExt = signImm;
	end

	assign aluA = ctrl.shiftOp ? rtData : (ctrl.link ? pc : rsData);
	assign aluB = ctrl.aluSrc ? immExt : rtData;

	alu alu_i (
		.a      (aluA),
		.b      (aluB),
		.op     (ctrl.aluOp),
		.result (aluResult),
		.zero   ()
	);

	dataMem dataMem_i (
		.clk   (clk),
		.we    (ctrl.memWrite && commit),
		.addr  (aluResult),
		.wdata (rtData),
		.rdata (memRdata)
	);

	assign writeReg  = ctrl.link ? `LINK_REG : (ctrl.regDst ? fields.rd : fields.rt);
	assign writeData = ctrl.memToReg ? memRdata : aluResult;

endmodule

/* bench/scCpu_sva.sv */
`timescale 1ns/1ps

module scCpu_sva import cpu_pkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     halted,
	input word_t    pc,
	input word_t    cyclesConsumed,
	input regAddr_t dbgAddr,
	input word_t    dbgData,
	input regAddr_t rsIdx,
	input word_t    rsData
);

	// --------------------------------------------------
	property frozenWhileHalted;
		@(posedge clk) disable iff (!rst)
		halted |=> $stable(pc) && $stable(cyclesConsumed);
	endproperty

	property haltSticky;
		@(posedge clk) disable iff (!rst)
		halted |=> halted; // only reset clears it
	endproperty

	property zeroRegDebug;
		@(posedge clk) disable iff (!rst)
		(dbgAddr == 5'd0) |-> (dbgData == '0);
	endproperty

	property zeroRegRead;
		@(posedge clk) disable iff (!rst)
		(rsIdx == 5'd0) |-> (rsData == '0);
	endproperty

	assert property (frozenWhileHalted) else $error("pc or cyclesConsumed moved while halted");
	assert property (haltSticky) else $error("halted fell while out of reset");
	assert property (zeroRegDebug) else $error("r0 is not zero on the debug port");
	assert property (zeroRegRead) else $error("r0 is not zero on read port 1");

endmodule

/* bench/scCpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module scCpu_tb import cpu_pkg::*; ();

	localparam int    NUM_ROWS    = 7;
	localparam int    MAX_WORDS   = 16;
	localparam int    CYCLE_LIMIT = 64 * NUM_ROWS;
	localparam word_t HLT_WORD    = {`OP_HLT, 26'd0};

	logic     clk;
	logic     rst;
	logic     loadEn;
	word_t    loadAddr;
	word_t    loadData;
	regAddr_t dbgAddr;
	word_t    pc;
	word_t    cyclesConsumed;
	logic     halted;
	word_t    dbgData;

	// program and expectation table, one row per test
	word_t    progMem [NUM_ROWS][MAX_WORDS];
	int       progLen [NUM_ROWS];
	int       expCount [NUM_ROWS];
	word_t    expPc [NUM_ROWS];
	regAddr_t expReg [NUM_ROWS][4];
	word_t    expVal [NUM_ROWS][4];
	int       rowIdx;
	int       runCycles = 0;

	scCpu scCpu_i (
		.clk            (clk),
		.rst            (rst),
		.loadEn         (loadEn),
		.loadAddr       (loadAddr),
		.loadData       (loadData),
		.dbgAddr        (dbgAddr),
		.pc             (pc),
		.cyclesConsumed (cyclesConsumed),
		.halted         (halted),
		.dbgData        (dbgData)
	);

	bind scCpu scCpu_sva scCpu_sva_i (
		.clk            (clk),
		.rst            (rst),
		.halted         (halted),
		.pc             (pc),
		.cyclesConsumed (cyclesConsumed),
		.dbgAddr        (dbgAddr),
		.dbgData        (dbgData),
		.rsIdx          (fields.rs),
		.rsData         (rsData)
	);

	always #2 clk = ~clk;

	// only cycles with the core out of reset count toward the limit
	always @(posedge clk) begin
		if (rst) begin
			runCycles++;
			if (runCycles > CYCLE_LIMIT) begin
				$display("CPU never halted within %0d cycles", CYCLE_LIMIT);
				$display("Simulation failed");
				$fatal(1, "timeout");
			end
		end
	end

	// --------------------------------------------------
	// instruction encoders
	function automatic word_t rInstr(input funct_t fn, input regAddr_t rs, input regAddr_t rt,
			input regAddr_t rd, input shamt_t sh);
		return {`OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t iInstr(input opcode_t op, input regAddr_t rs, input regAddr_t rt,
			input imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jInstr(input opcode_t op, input jTarget_t target);
		return {op, target};
	endfunction

	task automatic checkValue(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
			$display("Simulation failed");
			$fatal(1, "check failed");
		end
	endtask

	// --------------------------------------------------
	// table construction
	task automatic addWord(input word_t w);
		progMem[rowIdx][progLen[rowIdx]] = w;
		progLen[rowIdx]++;
	endtask

	task automatic closeRow(input int count, input word_t pcVal,
			input regAddr_t r0, input word_t v0, input regAddr_t r1, input word_t v1,
			input regAddr_t r2, input word_t v2, input regAddr_t r3, input word_t v3);
		expCount[rowIdx]  = count;
		expPc[rowIdx]     = pcVal;
		expReg[rowIdx][0] = r0;
		expVal[rowIdx][0] = v0;
		expReg[rowIdx][1] = r1;
		expVal[rowIdx][1] = v1;
		expReg[rowIdx][2] = r2;
		expVal[rowIdx][2] = v2;
		expReg[rowIdx][3] = r3;
		expVal[rowIdx][3] = v3;
		rowIdx++;
	endtask

	task automatic buildTable();
		rowIdx = 0;
		// add, sub and slt on negative values, addi sign extension
		addWord(iInstr(`OP_ADDI, 0, 1, 16'hFFFB));
		addWord(iInstr(`OP_ADDI, 0, 2, 16'h0007));
		addWord(rInstr(`FN_SUB, 1, 2, 5, 0));
		addWord(rInstr(`FN_SLT, 5, 1, 3, 0));
		addWord(rInstr(`FN_ADD, 1, 1, 4, 0));
		addWord(HLT_WORD);
		closeRow(6, 5, 1, 32'hFFFFFFFB, 5, 32'hFFFFFFF4, 3, 32'h1, 4, 32'hFFFFFFF6);
		// logic ops, immediates zero extended
		addWord(iInstr(`OP_ADDI, 0, 1, 16'hFFFF));
		addWord(iInstr(`OP_ANDI, 1, 2, 16'h8001));
		addWord(iInstr(`OP_XORI, 1, 3, 16'h8000));
		addWord(iInstr(`OP_ORI, 2, 4, 16'hF0F0));
		addWord(rInstr(`FN_AND, 3, 4, 5, 0));
		addWord(rInstr(`FN_OR, 5, 2, 5, 0));
		addWord(rInstr(`FN_XOR, 5, 3, 5, 0));
		addWord(HLT_WORD);
		closeRow(8, 7, 2, 32'h8001, 3, 32'hFFFF7FFF, 4, 32'hF0F1, 5, 32'hFFFF8F0E);
		// shifts and writes aimed at r0
		addWord(iInstr(`OP_ADDI, 0, 1, 16'hFFF0));
		addWord(rInstr(`FN_SLL, 0, 1, 2, 4));
		addWord(rInstr(`FN_SRL, 0, 1, 3, 28));
		addWord(rInstr(`FN_SRL, 0, 1, 4, 1));
		addWord(rInstr(`FN_SLL, 0, 1, 0, 3));
		addWord(iInstr(`OP_ADDI, 0, 0, 16'h0005));
		addWord(rInstr(`FN_ADD, 4, 0, 4, 0));
		addWord(HLT_WORD);
		closeRow(8, 7, 2, 32'hFFFFFF00, 3, 32'hF, 4, 32'h7FFFFFF8, 0, 32'h0);
		// stores then loads, word 11 must survive the store to word 10
		addWord(iInstr(`OP_ADDI, 0, 1, 16'h1234));
		addWord(iInstr(`OP_ADDI, 0, 2, 16'hFFFE));
		addWord(iInstr(`OP_ADDI, 0, 5, 16'h0004));
		addWord(iInstr(`OP_SW, 0, 2, 16'd11));
		addWord(iInstr(`OP_SW, 0, 1, 16'd10));
		addWord(iInstr(`OP_LW, 5, 3, 16'd6));
		addWord(iInstr(`OP_LW, 5, 4, 16'd7));
		addWord(HLT_WORD);
		closeRow(8, 7, 3, 32'h1234, 4, 32'hFFFFFFFE, 5, 32'h4, 2, 32'hFFFFFFFE);
		// branches and jumps, every write to r7 lies on a skipped path
		addWord(iInstr(`OP_ADDI, 0, 1, 16'd3));
		addWord(iInstr(`OP_ADDI, 0, 2, 16'd3));
		addWord(iInstr(`OP_BEQ, 1, 2, 16'd1));   // taken to 4
		addWord(iInstr(`OP_ADDI, 0, 7, 16'd1));
		addWord(iInstr(`OP_BNE, 1, 2, 16'd7));   // not taken
		addWord(jInstr(`OP_JAL, 26'd10));        // r31 gets 6
		addWord(iInstr(`OP_BNE, 1, 0, 16'd1));   // taken to 8
		addWord(iInstr(`OP_ADDI, 0, 7, 16'd2));
		addWord(jInstr(`OP_J, 26'd13));
		addWord(iInstr(`OP_ADDI, 0, 7, 16'd3));
		addWord(iInstr(`OP_ADDI, 0, 3, 16'h55));
		addWord(rInstr(`FN_JR, 31, 0, 0, 0));    // back to 6
		addWord(iInstr(`OP_ADDI, 0, 7, 16'd4));
		addWord(iInstr(`OP_BEQ, 1, 0, 16'd1));   // not taken
		addWord(HLT_WORD);
		closeRow(11, 14, 7, 32'h0, 31, 32'h6, 3, 32'h55, 1, 32'h3);
		// unknown opcode goes to the handler
		addWord(iInstr(`OP_ADDI, 0, 1, 16'd1));
		addWord(iInstr(6'h10, 0, 1, 16'h7777));
		addWord(iInstr(`OP_ADDI, 0, 4, 16'd1));
		closeRow(3, `HANDLER_ADDR, 1, 32'h1, 4, 32'h0, 0, 32'h0, 0, 32'h0);
		// unknown funct goes to the handler
		addWord(iInstr(`OP_ADDI, 0, 2, 16'd9));
		addWord(rInstr(6'h3F, 2, 2, 3, 0));
		addWord(iInstr(`OP_ADDI, 0, 4, 16'd1));
		closeRow(3, `HANDLER_ADDR, 2, 32'h9, 3, 32'h0, 4, 32'h0, 0, 32'h0);
	endtask

	// --------------------------------------------------
	// loading and running one row
	task automatic loadProgram(input int r);
		word_t w;
		for (int a = 0; a < `IMEM_DEPTH; a++) begin
			if (a < progLen[r])
				w = progMem[r][a];
			else if (a == `HANDLER_ADDR)
				w = HLT_WORD;
			else begin
				w = $urandom();
				if (w[31:26] == `OP_HLT)
					w[31:26] = `OP_ADDI; // filler must never stop the core
			end
			@(negedge clk);
			loadEn   = 1'b1;
			loadAddr = a;
			loadData = w;
		end
		@(negedge clk);
		loadEn = 1'b0;
	endtask

	task automatic runRow(input int r);
		@(negedge clk);
		rst = 1'b0;
		loadProgram(r);
		@(negedge clk);
		rst = 1'b1;
		do
			@(negedge clk);
		while (!halted);
		checkValue("pc", pc, expPc[r]);
		checkValue("cyclesConsumed", cyclesConsumed, word_t'(expCount[r]));
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			dbgAddr = expReg[r][k];
			#1;
			checkValue($sformatf("dbgData[r%0d]", expReg[r][k]), dbgData, expVal[r][k]);
		end
		repeat (5) @(negedge clk);
		checkValue("halted", {31'd0, halted}, 32'd1);
		checkValue("pc while halted", pc, expPc[r]);
		checkValue("cyclesConsumed while halted", cyclesConsumed, word_t'(expCount[r]));
	endtask

	initial begin
		clk      = 1'b0;
		rst      = 1'b0;
		loadEn   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		dbgAddr  = '0;
		void'($urandom(32'h9a1ed914));
		buildTable();
		repeat (4) @(negedge clk);
		for (int r = 0; r < NUM_ROWS; r++)
			runRow(r);
		$display("Simulation passed");
		$finish;
	end

endmodule

/* scCpu.f */
+incdir+common
common/cpu_pkg.sv
verilog/alu.sv
verilog/registerFile.sv
memory/instMem.sv
memory/dataMem.sv
decode/controlUnit.sv
decode/branchController.sv
verilog/scCpu.sv
bench/scCpu_sva.sv
bench/scCpu_tb.sv
